// ==== dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

//////////////////////////////////////////////////
// cache geometry

// byte address and load/store data
`define DC_ADDR_W   32
`define DC_XLEN     64

// 8-byte lines, 256 sets, tag is what is left
`define DC_OFFSET_W 3
`define DC_INDEX_W  8
`define DC_TAG_W    21
`define DC_SETS     256

//////////////////////////////////////////////////
// external buses

`define DC_WB_W     32
`define DC_ID_W     4

`endif

// ==== dcache_pkg.sv ====
`include "dcache_config.svh"

package dcache_pkg;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    // bit 2 set means zero-extended load
    typedef enum logic [2:0] {
        SZ_B  = 3'd0,
        SZ_H  = 3'd1,
        SZ_W  = 3'd2,
        SZ_D  = 3'd3,
        SZ_BU = 3'd4,
        SZ_HU = 3'd5,
        SZ_WU = 3'd6
    } mem_size_e;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]    tag;
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_OFFSET_W-1:0] offset;
    } dc_addr_t;

    typedef struct packed {
        mem_op_e              op;
        mem_size_e            size;
        dc_addr_t             addr;
        logic [`DC_XLEN-1:0]  wdata;
        logic [`DC_ID_W-1:0]  id;
    } dc_req_t;

    typedef struct packed {
        logic [`DC_XLEN-1:0] rdata;
        logic [`DC_ID_W-1:0] id;
    } dc_resp_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_EVICT,
        ST_REFILL,
        ST_FILL,
        ST_RESP
    } ctrl_state_e;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`DC_ADDR_W-1:0]  adr;
        logic [`DC_WB_W-1:0]    dat;
        logic [`DC_WB_W/8-1:0]  sel;
    } wb_req_t;

endpackage

// ==== dcache_align.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_align (
    input  dcache_pkg::mem_size_e     size_i,
    input  logic [`DC_OFFSET_W-1:0]   offset_i,
    input  logic [`DC_XLEN-1:0]       wdata_i,
    input  logic [`DC_XLEN-1:0]       line_i,
    output logic [`DC_XLEN/8-1:0]     be_o,
    output logic [`DC_XLEN-1:0]       wdata_o,
    output logic [`DC_XLEN-1:0]       rdata_o
);

    logic [`DC_XLEN/8-1:0] lanes;
    logic [`DC_XLEN-1:0]   field;

    //////////////////////////////////////////////////
    // store side

    always_comb begin
        case (size_i)
            dcache_pkg::SZ_B, dcache_pkg::SZ_BU: lanes = 8'h01;
            dcache_pkg::SZ_H, dcache_pkg::SZ_HU: lanes = 8'h03;
            dcache_pkg::SZ_W, dcache_pkg::SZ_WU: lanes = 8'h0f;
            default:                             lanes = 8'hff;
        endcase
    end

    assign be_o    = lanes << offset_i;
    assign wdata_o = wdata_i << {offset_i, 3'b000};

    //////////////////////////////////////////////////
    // load side

    // field lands in the low bytes
    assign field = line_i >> {offset_i, 3'b000};

    always_comb begin
        case (size_i)
            dcache_pkg::SZ_B:  rdata_o = {{(`DC_XLEN-8){field[7]}}, field[7:0]};
            dcache_pkg::SZ_H:  rdata_o = {{(`DC_XLEN-16){field[15]}}, field[15:0]};
            dcache_pkg::SZ_W:  rdata_o = {{(`DC_XLEN-32){field[31]}}, field[31:0]};
            dcache_pkg::SZ_BU: rdata_o = {{(`DC_XLEN-8){1'b0}}, field[7:0]};
            dcache_pkg::SZ_HU: rdata_o = {{(`DC_XLEN-16){1'b0}}, field[15:0]};
            dcache_pkg::SZ_WU: rdata_o = {{(`DC_XLEN-32){1'b0}}, field[31:0]};
            default:           rdata_o = field;
        endcase
    end

    // misaligned accesses are not split, upper lanes drop off

endmodule

// ==== dcache_tag_store.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tag_store (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`DC_INDEX_W-1:0]  index_i,
    input  logic [`DC_TAG_W-1:0]    lookup_tag_i,
    input  logic                    we_i,
    input  dcache_pkg::tag_entry_t  entry_i,
    output dcache_pkg::tag_entry_t  entry_o,
    output logic                    hit_o
);

    logic [`DC_SETS-1:0]  valid_q;
    logic [`DC_SETS-1:0]  dirty_q;
    logic [`DC_TAG_W-1:0] tag_mem [`DC_SETS];

    dcache_pkg::tag_entry_t rd_entry;
    dcache_pkg::tag_entry_t entry_q;
    logic [`DC_TAG_W-1:0]   lookup_tag_q;

    // single port, write-first
    always_comb begin
        if (we_i) begin
            rd_entry = entry_i;
        end else begin
            rd_entry.valid = valid_q[index_i];
            rd_entry.dirty = dirty_q[index_i];
            rd_entry.tag   = tag_mem[index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (rstn) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[index_i] <= entry_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            dirty_q[index_i] <= entry_i.dirty;
            tag_mem[index_i] <= entry_i.tag;
        end
        entry_q      <= rd_entry;
        lookup_tag_q <= lookup_tag_i;
    end

    assign entry_o = entry_q;
    assign hit_o   = entry_q.valid && (entry_q.tag == lookup_tag_q);

endmodule

// ==== dcache_data_store.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_data_store (
    input  logic                     clk,
    input  logic [`DC_INDEX_W-1:0]   index_i,
    input  logic [`DC_XLEN/8-1:0]    be_i,
    input  logic [`DC_XLEN-1:0]      wdata_i,
    output logic [`DC_XLEN-1:0]      rdata_o
);

    logic [`DC_XLEN-1:0] mem [`DC_SETS];
    logic [`DC_XLEN-1:0] line_nxt;

    // merge enabled lanes into the addressed line
    always_comb begin
        line_nxt = mem[index_i];
        for (int b = 0; b < `DC_XLEN/8; b++) begin
            if (be_i[b]) begin
                line_nxt[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    // read returns the merged line on a write
    always_ff @(posedge clk) begin
        if (|be_i) begin
            mem[index_i] <= line_nxt;
        end
        rdata_o <= line_nxt;
    end

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  dcache_pkg::dc_req_t      req_i,
    output logic                     resp_valid_o,
    input  logic                     resp_ready_i,
    output dcache_pkg::dc_resp_t     resp_o,
    output dcache_pkg::wb_req_t      wb_o,
    input  logic                     wb_ack_i,
    input  logic [`DC_WB_W-1:0]      wb_dat_i,
    output logic [`DC_INDEX_W-1:0]   index_o,
    output logic [`DC_TAG_W-1:0]     lookup_tag_o,
    output logic                     tag_we_o,
    output dcache_pkg::tag_entry_t   tag_entry_o,
    input  dcache_pkg::tag_entry_t   tag_entry_i,
    input  logic                     hit_i,
    output logic [`DC_XLEN/8-1:0]    data_be_o,
    output logic [`DC_XLEN-1:0]      data_wdata_o,
    input  logic [`DC_XLEN-1:0]      data_rdata_i
);

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::dc_req_t     req_q;
    dcache_pkg::dc_resp_t    resp_q;
    logic                    beat_q;
    logic [`DC_XLEN-1:0]     fill_line_q;
    logic [`DC_XLEN/8-1:0]   st_be;
    logic [`DC_XLEN-1:0]     st_wdata;
    logic [`DC_XLEN-1:0]     ld_data;
    logic                    is_store;
    logic                    in_lookup;
    logic                    in_fill;
    logic                    st_hit;
    logic                    wb_active;

    assign is_store  = (req_q.op == dcache_pkg::OP_STORE);
    assign in_lookup = (state_q == dcache_pkg::ST_LOOKUP);
    assign in_fill   = (state_q == dcache_pkg::ST_FILL);
    assign st_hit    = in_lookup && hit_i && is_store;

    dcache_align u_align (
        .size_i   (req_q.size),
        .offset_i (req_q.addr.offset),
        .wdata_i  (req_q.wdata),
        .line_i   (data_rdata_i),
        .be_o     (st_be),
        .wdata_o  (st_wdata),
        .rdata_o  (ld_data)
    );

    //////////////////////////////////////////////////
    // array side

    assign req_ready_o  = (state_q == dcache_pkg::ST_IDLE);
    assign index_o      = req_ready_o ? req_i.addr.index : req_q.addr.index;
    assign lookup_tag_o = req_ready_o ? req_i.addr.tag : req_q.addr.tag;

    // refill lands clean, store hit marks dirty
    assign tag_we_o     = st_hit || in_fill;
    assign tag_entry_o  = '{valid: 1'b1, dirty: !in_fill, tag: req_q.addr.tag};
    assign data_be_o    = in_fill ? '1 : (st_hit ? st_be : '0);
    assign data_wdata_o = in_fill ? fill_line_q : st_wdata;

    assign resp_valid_o = (state_q == dcache_pkg::ST_RESP);
    assign resp_o       = resp_q;

    //////////////////////////////////////////////////
    // wishbone master

    // victim line stays on the array outputs while evicting
    assign wb_active = (state_q == dcache_pkg::ST_EVICT) || (state_q == dcache_pkg::ST_REFILL);

    always_comb begin
        wb_o.cyc = wb_active;
        wb_o.stb = wb_active;
        wb_o.we  = (state_q == dcache_pkg::ST_EVICT);
        wb_o.sel = '1;
        if (wb_o.we) begin
            wb_o.adr = {tag_entry_i.tag, req_q.addr.index, beat_q, 2'b00};
        end else begin
            wb_o.adr = {req_q.addr.tag, req_q.addr.index, beat_q, 2'b00};
        end
        wb_o.dat = beat_q ? data_rdata_i[`DC_XLEN-1 -: `DC_WB_W] : data_rdata_i[`DC_WB_W-1:0];
    end

    //////////////////////////////////////////////////
    // request fsm

    always_ff @(posedge clk) begin
        if (rstn) begin
            state_q <= dcache_pkg::ST_IDLE;
            beat_q  <= 1'b0;
        end else begin
            case (state_q)
                dcache_pkg::ST_IDLE: begin
                    if (req_valid_i) state_q <= dcache_pkg::ST_LOOKUP;
                end
                dcache_pkg::ST_LOOKUP: begin
                    if (hit_i) begin
                        state_q <= is_store ? dcache_pkg::ST_IDLE : dcache_pkg::ST_RESP;
                    end else if (tag_entry_i.valid && tag_entry_i.dirty) begin
                        state_q <= dcache_pkg::ST_EVICT;
                    end else begin
                        state_q <= dcache_pkg::ST_REFILL;
                    end
                end
                dcache_pkg::ST_EVICT, dcache_pkg::ST_REFILL: begin
                    if (wb_ack_i) begin
                        beat_q <= ~beat_q;
                        if (beat_q) begin
                            state_q <= wb_o.we ? dcache_pkg::ST_REFILL : dcache_pkg::ST_FILL;
                        end
                    end
                end
                // replay as a hit
                dcache_pkg::ST_FILL: state_q <= dcache_pkg::ST_LOOKUP;
                dcache_pkg::ST_RESP: begin
                    if (resp_ready_i) state_q <= dcache_pkg::ST_IDLE;
                end
                default: state_q <= dcache_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) req_q <= req_i;
        if (in_lookup && hit_i && !is_store) resp_q <= '{rdata: ld_data, id: req_q.id};
        // low word arrives first
        if (state_q == dcache_pkg::ST_REFILL && wb_ack_i) begin
            if (beat_q) begin
                fill_line_q[`DC_XLEN-1 -: `DC_WB_W] <= wb_dat_i;
            end else begin
                fill_line_q[`DC_WB_W-1:0] <= wb_dat_i;
            end
        end
    end

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  dcache_pkg::dc_req_t   req_i,
    output logic                  resp_valid_o,
    input  logic                  resp_ready_i,
    output dcache_pkg::dc_resp_t  resp_o,
    output dcache_pkg::wb_req_t   wb_o,
    input  logic                  wb_ack_i,
    input  logic [`DC_WB_W-1:0]   wb_dat_i
);

    logic [`DC_INDEX_W-1:0]  index;
    logic [`DC_TAG_W-1:0]    lookup_tag;
    logic                    tag_we;
    dcache_pkg::tag_entry_t  tag_wentry;
    dcache_pkg::tag_entry_t  tag_rentry;
    logic                    hit;
    logic [`DC_XLEN/8-1:0]   data_be;
    logic [`DC_XLEN-1:0]     data_wdata;
    logic [`DC_XLEN-1:0]     data_rdata;

    dcache_ctrl u_ctrl (
        .clk          (clk),          .rstn          (rstn),
        .req_valid_i  (req_valid_i),  .req_ready_o   (req_ready_o),
        .req_i        (req_i),        .resp_valid_o  (resp_valid_o),
        .resp_ready_i (resp_ready_i), .resp_o        (resp_o),
        .wb_o         (wb_o),         .wb_ack_i      (wb_ack_i),
        .wb_dat_i     (wb_dat_i),     .index_o       (index),
        .lookup_tag_o (lookup_tag),   .tag_we_o      (tag_we),
        .tag_entry_o  (tag_wentry),   .tag_entry_i   (tag_rentry),
        .hit_i        (hit),          .data_be_o     (data_be),
        .data_wdata_o (data_wdata),   .data_rdata_i  (data_rdata)
    );

    dcache_tag_store u_tag_store (
        .clk          (clk),          .rstn          (rstn),
        .index_i      (index),        .lookup_tag_i  (lookup_tag),
        .we_i         (tag_we),       .entry_i       (tag_wentry),
        .entry_o      (tag_rentry),   .hit_o         (hit)
    );

    dcache_data_store u_data_store (
        .clk          (clk),          .index_i       (index),
        .be_i         (data_be),      .wdata_i       (data_wdata),
        .rdata_o      (data_rdata)
    );

endmodule

// ==== dcache_asserts.sv ====
`timescale 1ns/1ps

module dcache_asserts (
    input logic                 clk,
    input logic                 rstn,
    input logic                 ready_i,
    input logic                 resp_valid_i,
    input logic                 resp_ready_i,
    input dcache_pkg::dc_resp_t resp_i,
    input dcache_pkg::wb_req_t  wb_i
);

    // response held while the core stalls
    resp_stable_a: assert property (@(posedge clk) disable iff (rstn)
        resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
    else $error("response changed or dropped under back-pressure");

    no_accept_in_resp_a: assert property (@(posedge clk) disable iff (rstn)
        resp_valid_i |-> !ready_i)
    else $error("request side ready while a response is pending");

    stb_in_cyc_a: assert property (@(posedge clk) disable iff (rstn)
        wb_i.stb |-> wb_i.cyc)
    else $error("wishbone strobe without cycle");

    // first cycle out of reset is quiet
    quiet_after_reset_a: assert property (@(posedge clk)
        $fell(rstn) |-> !wb_i.cyc && !resp_valid_i)
    else $error("bus cycle or response right after reset");

endmodule

// ==== dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb;

    localparam int NROWS      = 20;
    localparam int MAX_CYCLES = NROWS * 40 + 10;

    localparam dcache_pkg::mem_op_e   LD = dcache_pkg::OP_LOAD;
    localparam dcache_pkg::mem_op_e   ST = dcache_pkg::OP_STORE;
    localparam dcache_pkg::mem_size_e B  = dcache_pkg::SZ_B;
    localparam dcache_pkg::mem_size_e H  = dcache_pkg::SZ_H;
    localparam dcache_pkg::mem_size_e W  = dcache_pkg::SZ_W;
    localparam dcache_pkg::mem_size_e D  = dcache_pkg::SZ_D;
    localparam dcache_pkg::mem_size_e BU = dcache_pkg::SZ_BU;
    localparam dcache_pkg::mem_size_e HU = dcache_pkg::SZ_HU;
    localparam dcache_pkg::mem_size_e WU = dcache_pkg::SZ_WU;

    typedef struct {
        string                 name;
        dcache_pkg::mem_op_e   op;
        dcache_pkg::mem_size_e size;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_XLEN-1:0]   wdata;
        logic [`DC_XLEN-1:0]   rdata;
        bit                    resp;
        int                    beats;
        bit                    bp;
    } row_t;

    logic                  clk;
    logic                  rstn;
    logic                  req_valid_i;
    logic                  req_ready_o;
    dcache_pkg::dc_req_t   req_i;
    logic                  resp_valid_o;
    logic                  resp_ready_i;
    dcache_pkg::dc_resp_t  resp_o;
    dcache_pkg::wb_req_t   wb_o;
    logic                  wb_ack_i;
    logic [`DC_WB_W-1:0]   wb_dat_i;

    row_t                  rows [NROWS];
    int                    n_rows;
    logic [`DC_WB_W-1:0]   mem_words [logic [`DC_ADDR_W-1:0]];
    dcache_pkg::wb_req_t   wb_seen;
    dcache_pkg::wb_req_t   wr_beats [$];
    int                    beat_cnt;
    int                    ack_delay;
    int                    cycles;
    int                    checks;
    int                    errors;
    logic [`DC_ADDR_W-1:0] evict_adr;
    logic [`DC_XLEN-1:0]   evict_line;

    dcache_top UUT (
        .clk          (clk),          .rstn          (rstn),
        .req_valid_i  (req_valid_i),  .req_ready_o   (req_ready_o),
        .req_i        (req_i),        .resp_valid_o  (resp_valid_o),
        .resp_ready_i (resp_ready_i), .resp_o        (resp_o),
        .wb_o         (wb_o),         .wb_ack_i      (wb_ack_i),
        .wb_dat_i     (wb_dat_i)
    );

    bind dcache_top dcache_asserts u_asserts (
        .clk          (clk),          .rstn          (rstn),
        .ready_i      (req_ready_o),  .resp_valid_i  (resp_valid_o),
        .resp_ready_i (resp_ready_i), .resp_i        (resp_o),
        .wb_i         (wb_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // wishbone memory

    function automatic logic [`DC_WB_W-1:0] read_word(input logic [`DC_ADDR_W-1:0] adr);
        if (mem_words.exists(adr)) begin
            return mem_words[adr];
        end
        return adr ^ 32'hA5A5_0000;
    endfunction

    // bus request as seen in the middle of the cycle
    always @(negedge clk) wb_seen = wb_o;

    always @(posedge clk) begin
        wb_ack_i <= 1'b0;
        if (wb_seen.cyc && wb_seen.stb && !wb_ack_i) begin
            if (ack_delay > 0) begin
                ack_delay--;
            end else begin
                wb_ack_i <= 1'b1;
                beat_cnt++;
                if (wb_seen.we) begin
                    mem_words[wb_seen.adr] = wb_seen.dat;
                    wr_beats.push_back(wb_seen);
                end else begin
                    wb_dat_i <= read_word(wb_seen.adr);
                end
                ack_delay = $urandom_range(3, 0);
            end
        end
    end

    //////////////////////////////////////////////////
    // checks

    task automatic check_resp(input string name, input dcache_pkg::dc_resp_t exp,
                              input dcache_pkg::dc_resp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected rdata %h id %h, got rdata %h id %h",
                     name, exp.rdata, exp.id, act.rdata, act.id);
        end
    endtask

    task automatic check_wb(input string name, input dcache_pkg::wb_req_t exp,
                            input dcache_pkg::wb_req_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected beat we %b adr %h dat %h, got we %b adr %h dat %h",
                     name, exp.we, exp.adr, exp.dat, act.we, act.adr, act.dat);
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[FAIL] %s: expected %0d %s, got %0d", name, exp, what, act);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus table

    task automatic add_row(input string name, input dcache_pkg::mem_op_e op,
                           input dcache_pkg::mem_size_e size, input logic [31:0] addr,
                           input logic [63:0] wdata, input logic [63:0] rdata,
                           input bit resp, input int beats, input bit bp);
        rows[n_rows] = '{name, op, size, addr, wdata, rdata, resp, beats, bp};
        n_rows++;
    endtask

    task automatic fill_table();
        // set 0x46 holds A5A5_1234_A5A5_1230 from the pattern
        add_row("cold_ld_w", LD, W, 32'h1234, 64'h0, 64'hFFFF_FFFF_A5A5_1234, 1, 2, 0);
        add_row("hit_ld_b", LD, B, 32'h1232, 64'h0, 64'hFFFF_FFFF_FFFF_FFA5, 1, 0, 0);
        add_row("hit_ld_bu", LD, BU, 32'h1233, 64'h0, 64'h0000_0000_0000_00A5, 1, 0, 0);
        add_row("hit_ld_h", LD, H, 32'h1236, 64'h0, 64'hFFFF_FFFF_FFFF_A5A5, 1, 0, 0);
        add_row("hit_ld_hu", LD, HU, 32'h1234, 64'h0, 64'h0000_0000_0000_1234, 1, 0, 0);
        add_row("hit_ld_wu", LD, WU, 32'h1230, 64'h0, 64'h0000_0000_A5A5_1230, 1, 0, 0);
        add_row("hit_ld_d", LD, D, 32'h1230, 64'h0, 64'hA5A5_1234_A5A5_1230, 1, 0, 0);
        // each store merges into the line left by the rows above
        add_row("st_b", ST, B, 32'h1231, 64'h5A, 64'h0, 0, 0, 0);
        add_row("ld_b_merged", LD, D, 32'h1230, 64'h0, 64'hA5A5_1234_A5A5_5A30, 1, 0, 0);
        add_row("st_h", ST, H, 32'h1236, 64'hBEEF, 64'h0, 0, 0, 0);
        add_row("ld_h_merged", LD, H, 32'h1236, 64'h0, 64'hFFFF_FFFF_FFFF_BEEF, 1, 0, 0);
        add_row("st_w", ST, W, 32'h1230, 64'h1357_9BDF, 64'h0, 0, 0, 0);
        add_row("ld_w_merged", LD, D, 32'h1230, 64'h0, 64'hBEEF_1234_1357_9BDF, 1, 0, 0);
        add_row("st_d", ST, D, 32'h1230, 64'h0123_4567_89AB_CDEF, 64'h0, 0, 0, 0);
        add_row("ld_d_merged", LD, W, 32'h1234, 64'h0, 64'h0000_0000_0123_4567, 1, 0, 0);
        // tag 3 in the same set pushes the dirty line out
        add_row("evict_ld_wu", LD, WU, 32'h1A30, 64'h0, 64'h0000_0000_A5A5_1A30, 1, 4, 1);
        add_row("reload_ld_d", LD, D, 32'h1230, 64'h0, 64'h0123_4567_89AB_CDEF, 1, 2, 0);
        add_row("stall_ld_hu", LD, HU, 32'h1232, 64'h0, 64'h0000_0000_0000_89AB, 1, 0, 1);
        add_row("st_miss_b", ST, B, 32'h2005, 64'h77, 64'h0, 0, 2, 0);
        add_row("ld_after_miss", LD, D, 32'h2000, 64'h0, 64'hA5A5_7704_A5A5_2000, 1, 0, 0);
        evict_adr  = 32'h1230;
        evict_line = 64'h0123_4567_89AB_CDEF;
    endtask

    task automatic run_row(input int r);
        row_t                 row;
        dcache_pkg::dc_req_t  req;
        dcache_pkg::dc_resp_t exp_resp;
        dcache_pkg::wb_req_t  exp_beat;
        int                   lat;
        int                   errs_before;
        row         = rows[r];
        errs_before = errors;
        req.op      = row.op;
        req.size    = row.size;
        req.addr    = row.addr;
        req.wdata   = row.wdata;
        req.id      = r[`DC_ID_W-1:0];
        @(negedge clk);
        beat_cnt = 0;
        wr_beats.delete();
        @(posedge clk);
        req_valid_i  <= 1'b1;
        req_i        <= req;
        resp_ready_i <= !row.bp;
        // cache is idle here, so this edge accepts
        @(posedge clk);
        req_valid_i <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (row.resp ? !resp_valid_o : !req_ready_o);
        if (row.beats == 0) begin
            check_count(row.name, "cycles from accept to done", 2, lat);
        end
        if (row.resp) begin
            exp_resp.rdata = row.rdata;
            exp_resp.id    = req.id;
            check_resp(row.name, exp_resp, resp_o);
            if (row.bp) begin
                repeat ($urandom_range(5, 1)) begin
                    @(negedge clk);
                    check_resp(row.name, exp_resp, resp_o);
                    if (req_ready_o || !resp_valid_o) begin
                        errors++;
                        $display("%s: response dropped or request side opened during stall",
                                 row.name);
                    end
                end
                @(posedge clk);
                resp_ready_i <= 1'b1;
            end
        end
        do @(negedge clk); while (!req_ready_o);
        check_count(row.name, "wishbone beats", row.beats, beat_cnt);
        check_count(row.name, "write beats", (row.beats == 4) ? 2 : 0, wr_beats.size());
        for (int b = 0; b < wr_beats.size(); b++) begin
            exp_beat = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: evict_adr + 32'(4 * b),
                         dat: evict_line[`DC_WB_W*b +: `DC_WB_W], sel: 4'hF};
            check_wb(row.name, exp_beat, wr_beats[b]);
        end
        if (errors == errs_before) begin
            $display("row %0d %s: ok", r, row.name);
        end else begin
            $display("row %0d %s: %0d mismatches", r, row.name, errors - errs_before);
        end
    endtask

    initial begin
        void'($urandom(42044));
        clk          = 1'b0;
        rstn         = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b1;
        wb_ack_i     = 1'b0;
        wb_dat_i     = '0;
        beat_cnt     = 0;
        ack_delay    = 0;
        cycles       = 0;
        checks       = 0;
        errors       = 0;
        n_rows       = 0;
        fill_table();
        repeat (3) @(posedge clk);
        rstn <= 1'b0;
        @(negedge clk);
        if (req_ready_o !== 1'b1 || resp_valid_o !== 1'b0 || wb_o.cyc !== 1'b0) begin
            errors++;
            $display("cache not idle after reset: ready %b resp_valid %b cyc %b",
                     req_ready_o, resp_valid_o, wb_o.cyc);
        end
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("%0d rows, %0d checks, %0d errors", NROWS, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== dcache_top.f ====
+incdir+.
dcache_pkg.sv
dcache_align.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_ctrl.sv
dcache_top.sv
dcache_asserts.sv
dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - .

sources:
  - dcache_pkg.sv
  - dcache_align.sv
  - dcache_tag_store.sv
  - dcache_data_store.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - dcache_asserts.sv
      - dcache_tb.sv
